/* hdl/ex_alu.sv */
/*
  Single-cycle integer ALU, purely combinational.
  Shifts use the low bits of operand B only.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_alu
  import ex_ops_pkg::*;
  import ex_port_pkg::*;
(
  input  alu_req_t        req_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_o     // Branch / SLT outcome
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;       // Signed a < b
  logic               lt_u;       // Unsigned a < b
  logic               eq;

  assign shamt = req_i.op_b[SHAMT_W-1:0];
  assign lt_s  = $signed(req_i.op_a) < $signed(req_i.op_b);
  assign lt_u  = req_i.op_a < req_i.op_b;
  assign eq    = req_i.op_a == req_i.op_b;

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////
  always_comb begin
    unique case (req_i.op)
      ALU_SLT,
      ALU_BLT:  cmp_o = lt_s;
      ALU_SLTU: cmp_o = lt_u;
      ALU_BEQ:  cmp_o = eq;
      ALU_BNE:  cmp_o = ~eq;
      ALU_BGE:  cmp_o = ~lt_s;
      default:  cmp_o = 1'b0;     // Non-compare ops
    endcase
  end

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////
  always_comb begin
    unique case (req_i.op)
      ALU_ADD: result_o = req_i.op_a + req_i.op_b;
      ALU_SUB: result_o = req_i.op_a - req_i.op_b;
      ALU_AND: result_o = req_i.op_a & req_i.op_b;
      ALU_OR:  result_o = req_i.op_a | req_i.op_b;
      ALU_XOR: result_o = req_i.op_a ^ req_i.op_b;
      ALU_SLL: result_o = req_i.op_a << shamt;
      ALU_SRL: result_o = req_i.op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA: result_o = $signed(req_i.op_a) >>> shamt;
      // Compares give 0 or 1, branches included
      default: result_o = {{(XLEN-1){1'b0}}, cmp_o};
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ex_mult.sv */
/*
  Two-cycle multiplier, MUL and signed 4x8 DOT8 with accumulate.
  Result holds while busy until the stage accepts it (ex_ready_i).
*/
`timescale 1ns/1ps
`default_nettype none

module ex_mult
  import ex_ops_pkg::*;
  import ex_port_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             en_i,
  input  mult_req_t       req_i,
  input  wire             ex_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            ready_o,
  output logic            multicycle_o
);

  localparam int PROD_W = 2 * BYTE_W;   // Signed byte product width

  logic                            busy_q;    // Second cycle, result valid
  logic                            start;

  // First cycle products
  logic [XLEN-1:0]                 mul_lo_d;
  logic [N_LANES-1:0][PROD_W-1:0]  bprod_d;

  // Operands / partial results for cycle two
  mult_op_e                        op_q;
  logic [XLEN-1:0]                 mul_lo_q;
  logic [N_LANES-1:0][PROD_W-1:0]  bprod_q;
  logic [XLEN-1:0]                 acc_q;     // DOT8 operand C
  logic [XLEN-1:0]                 dot_sum;

  assign start        = en_i & ~busy_q;  // Idle unit sees a new op
  assign multicycle_o = start;
  assign ready_o      = ~start;

  ////////////////////////////////////////
  // Cycle one, products
  ////////////////////////////////////////
  assign mul_lo_d = req_i.op_a * req_i.op_b;  // Low word only

  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      bprod_d[i] = $signed(req_i.op_a[i*BYTE_W +: BYTE_W])
                 * $signed(req_i.op_b[i*BYTE_W +: BYTE_W]);
    end
  end

  // Payload, loaded only when an op starts
  always_ff @(posedge clk) begin
    if (start) begin
      op_q     <= req_i.op;
      mul_lo_q <= mul_lo_d;
      bprod_q  <= bprod_d;
      acc_q    <= req_i.op_c;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
    end else if (ex_ready_i) begin
      busy_q <= 1'b0;                  // Stage took the result
    end
  end

  ////////////////////////////////////////
  // Cycle two, reduction
  ////////////////////////////////////////
  always_comb begin
    logic [XLEN-1:0] sum;
    sum = acc_q;
    for (int i = 0; i < N_LANES; i++) begin
      sum = sum + {{(XLEN-PROD_W){bprod_q[i][PROD_W-1]}}, bprod_q[i]}; // Sign extend
    end
    dot_sum = sum;
  end

  assign result_o = (op_q == MULT_DOT8) ? dot_sum : mul_lo_q;

endmodule

`default_nettype wire

/* hdl/ex_ops_pkg.sv */
/*
  Operation encodings and widths of the execute stage.
  Byte lanes assume XLEN is a multiple of BYTE_W.
*/
`default_nettype none

package ex_ops_pkg;

  ////////////////////////////////////////
  // Data and address widths
  ////////////////////////////////////////
  localparam int XLEN       = 32;           // Datapath width
  localparam int REG_AW     = 6;            // GPR address width
  localparam int BYTE_W     = 8;            // Dot product lane width
  localparam int N_LANES    = XLEN / BYTE_W; // Lanes per word
  localparam int WSPR_IW    = 2;            // Weight register index width
  localparam int N_WSPR_DEF = 4;            // Default weight bank depth

  ////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,  // Signed set-less-than
    ALU_SLTU = 4'h9,  // Unsigned set-less-than
    ALU_BEQ  = 4'hA,  // Branch ops only drive the compare flag
    ALU_BNE  = 4'hB,
    ALU_BLT  = 4'hC,  // Signed
    ALU_BGE  = 4'hD   // Signed
  } alu_op_e;

  ////////////////////////////////////////
  // Multiplier operators
  ////////////////////////////////////////
  typedef enum logic {
    MULT_MUL  = 1'b0, // Low word of A*B
    MULT_DOT8 = 1'b1  // Sum of signed byte products plus C
  } mult_op_e;

endpackage

`default_nettype wire

/* hdl/ex_port_pkg.sv */
/*
  Request and write-back bundles of the execute stage.
  Field order is MSB first, operator on top.
*/
`default_nettype none

package ex_port_pkg;

  import ex_ops_pkg::*;

  ////////////////////////////////////////
  // Requests from ID
  ////////////////////////////////////////

  // ALU request, op_b doubles as jump target
  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
  } alu_req_t;

  // Multiplier request, op_c is the DOT8 accumulator
  typedef struct packed {
    mult_op_e        op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] op_c;
  } mult_req_t;

  // Weight register select
  typedef struct packed {
    logic               valid; // Register named below is used
    logic [WSPR_IW-1:0] idx;
  } spr_sel_t;

  ////////////////////////////////////////
  // Register file write ports
  ////////////////////////////////////////

  // Forward port, ALU / MUL / CSR
  typedef struct packed {
    logic              we;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   wdata;
  } fw_port_t;

  // Load write-back port
  typedef struct packed {
    logic              we;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   wdata;
  } wb_port_t;

endpackage

`default_nettype wire

/* hdl/ex_stage.sv */
/*
  Execute stage top, ALU, multiplier, weight bank and write-back.
  No handshake of its own, ID holds inputs while ex_ready_o is low.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_ops_pkg::*;
  import ex_port_pkg::*;
#(
  parameter int N_WSPR = N_WSPR_DEF
) (
  input  wire               clk,
  input  wire               rst_n,
  // From ID
  input  alu_req_t          alu_req_i,
  input  wire               alu_en_i,
  input  mult_req_t         mult_req_i,
  input  wire               mult_en_i,
  input  spr_sel_t          mult_spr_sel_i,   // Weight register replaces op_a
  input  wire               csr_access_i,
  input  wire  [XLEN-1:0]   csr_rdata_i,
  input  wire               regfile_alu_we_i,
  input  wire  [REG_AW-1:0] regfile_alu_waddr_i,
  input  wire               regfile_we_i,
  input  wire  [REG_AW-1:0] regfile_waddr_i,
  input  wire               lsu_en_i,
  input  spr_sel_t          lsu_spr_sel_i,
  input  wire               branch_in_ex_i,
  // From LSU / WB
  input  wire               lsu_ready_ex_i,
  input  wire               lsu_err_i,
  input  wire  [XLEN-1:0]   lsu_rdata_i,
  input  wire               wb_ready_i,
  // Outputs
  output fw_port_t          fw_port_o,
  output wb_port_t          wb_port_o,
  output logic              branch_decision_o,
  output logic [XLEN-1:0]   jump_target_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;
  logic [XLEN-1:0] wspr_rdata;
  mult_req_t       mult_req;      // Request after weight substitution
  spr_sel_t        spr_wr;
  logic            spr_wr_en;

  // Weight register as operand A
  always_comb begin
    mult_req = mult_req_i;
    if (mult_spr_sel_i.valid) mult_req.op_a = wspr_rdata;
  end

  assign jump_target_o = alu_req_i.op_b;

  ex_alu u_alu (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (branch_decision_o)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .req_i        (mult_req),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_weight_spr #(.N_WSPR(N_WSPR)) u_wspr (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_i     (spr_wr),
    .wr_en_i  (spr_wr_en),
    .wdata_i  (lsu_rdata_i),
    .rd_sel_i (mult_spr_sel_i),
    .rdata_o  (wspr_rdata)
  );

  ex_writeback #(.N_WSPR(N_WSPR)) u_wb (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .mult_en_i           (mult_en_i),
    .mult_ready_i        (mult_ready),
    .alu_en_i            (alu_en_i),
    .csr_access_i        (csr_access_i),
    .csr_rdata_i         (csr_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .lsu_en_i            (lsu_en_i),
    .lsu_spr_sel_i       (lsu_spr_sel_i),
    .lsu_err_i           (lsu_err_i),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .fw_port_o           (fw_port_o),
    .wb_port_o           (wb_port_o),
    .spr_wr_o            (spr_wr),
    .spr_wr_en_o         (spr_wr_en),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

`default_nettype wire

/* hdl/ex_weight_spr.sv */
/*
  Weight register bank, written by loads, read by DOT8.
  Indices at or beyond N_WSPR are ignored on write and read as zero.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_weight_spr
  import ex_ops_pkg::*;
  import ex_port_pkg::*;
#(
  parameter int N_WSPR = N_WSPR_DEF
) (
  input  wire             clk,
  input  wire             rst_n,
  input  spr_sel_t        wr_i,
  input  wire             wr_en_i,
  input  wire [XLEN-1:0]  wdata_i,
  input  spr_sel_t        rd_sel_i,
  output logic [XLEN-1:0] rdata_o
);

  logic [N_WSPR-1:0][XLEN-1:0] wspr_q;

  ////////////////////////////////////////
  // Write, one register per strobe
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '0;                     // Weights start at zero
    end else if (wr_en_i && wr_i.valid) begin
      for (int i = 0; i < N_WSPR; i++) begin
        if (int'(wr_i.idx) == i) begin
          wspr_q[i] <= wdata_i;
        end
      end
    end
  end

  // Combinational read
  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < N_WSPR; i++) begin
      if (rd_sel_i.valid && int'(rd_sel_i.idx) == i) begin
        rdata_o = wspr_q[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ex_writeback.sv */
/*
  Forward port mux, EX/WB register and stage ready / valid.
  Load data arrives from the LSU in the write-back cycle itself.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_writeback
  import ex_ops_pkg::*;
  import ex_port_pkg::*;
#(
  parameter int N_WSPR = N_WSPR_DEF
) (
  input  wire               clk,
  input  wire               rst_n,
  // Unit results
  input  wire  [XLEN-1:0]   alu_result_i,
  input  wire  [XLEN-1:0]   mult_result_i,
  input  wire               mult_en_i,
  input  wire               mult_ready_i,
  input  wire               alu_en_i,
  input  wire               csr_access_i,
  input  wire  [XLEN-1:0]   csr_rdata_i,
  // Destinations from ID
  input  wire               regfile_alu_we_i,
  input  wire  [REG_AW-1:0] regfile_alu_waddr_i,
  input  wire               regfile_we_i,
  input  wire  [REG_AW-1:0] regfile_waddr_i,
  input  wire               lsu_en_i,
  input  spr_sel_t          lsu_spr_sel_i,
  // LSU / WB side
  input  wire               lsu_err_i,
  input  wire               lsu_ready_ex_i,
  input  wire  [XLEN-1:0]   lsu_rdata_i,
  input  wire               wb_ready_i,
  input  wire               branch_in_ex_i,
  output fw_port_t          fw_port_o,
  output wb_port_t          wb_port_o,
  output spr_sel_t          spr_wr_o,
  output logic              spr_wr_en_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  logic              units_ready;   // Nothing stalls EX
  logic              ex_valid;
  logic              we_q;          // Load write pending in WB
  logic [REG_AW-1:0] waddr_q;
  spr_sel_t          spr_q;         // Load target is a weight register

  ////////////////////////////////////////
  // Forward port, CSR > MUL > ALU
  ////////////////////////////////////////
  always_comb begin
    fw_port_o.we    = regfile_alu_we_i;
    fw_port_o.waddr = regfile_alu_waddr_i;
    if (csr_access_i) fw_port_o.wdata = csr_rdata_i;
    else if (mult_en_i) fw_port_o.wdata = mult_result_i;
    else fw_port_o.wdata = alu_result_i;
  end

  // Ready / valid
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign ex_ready_o  = units_ready | branch_in_ex_i;  // Branches finish in EX
  assign ex_valid    = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;
  assign ex_valid_o  = ex_valid;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
      spr_q   <= '0;
    end else if (ex_valid) begin
      we_q    <= regfile_we_i & ~lsu_err_i; // Faulted load never writes
      waddr_q <= regfile_waddr_i;
      spr_q   <= lsu_spr_sel_i;
    end else if (wb_ready_i) begin
      we_q    <= 1'b0;                      // Bubble into WB
    end
  end

  // Load write-back, GPR or weight register
  assign wb_port_o.we    = we_q & ~spr_q.valid;
  assign wb_port_o.waddr = waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

  assign spr_wr_o    = spr_q;
  assign spr_wr_en_o = we_q & spr_q.valid & (int'(spr_q.idx) < N_WSPR); // Drop bad index

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
# Exit status is nonzero unless the run reports a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_ex_stage \
  -f verilog.f -o sim_ex_stage || { echo "run.sh: build failed"; exit 1; }

out=$(./obj_dir/sim_ex_stage)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

/* tb/ex_stage_chk.sv */
/*
  Concurrent timing checks of the execute stage bound into ex_stage.
  Sampled on the rising edge and idle while rst_n is low.
*/
`timescale 1ns/1ps
`default_nettype none

module ex_stage_chk (
  input wire clk,
  input wire rst_n,
  input wire mult_multicycle_i,
  input wire ex_valid_i,
  input wire lsu_ready_ex_i,
  input wire wb_ready_i,
  input wire lsu_spr_valid_i, // Load from ID targets a weight register
  input wire wb_we_i          // Load write-back enable
);

  ////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////

  // Start pulse is a single cycle per op
  mult_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_i |=> !mult_multicycle_i)
    else $error("mult_multicycle_o high for two cycles in a row");

  ////////////////////////////////////////
  // Stage ready / valid
  ////////////////////////////////////////

  // No valid op while WB, LSU or a starting multiply stalls EX
  valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> (wb_ready_i && lsu_ready_ex_i && !mult_multicycle_i))
    else $error("ex_valid_o high while the stage is stalled");

  ////////////////////////////////////////
  // Load write-back
  ////////////////////////////////////////

  // Captured weight target never reaches the GPR port
  no_gpr_for_spr: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_i && lsu_spr_valid_i) |=> !wb_we_i)
    else $error("wb_port_o.we high for a load into a weight register");

  // Bubble into WB
  bubble_clears_we: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ready_i && !ex_valid_i) |=> !wb_we_i)
    else $error("wb_port_o.we high after a cycle with no valid EX op");

endmodule

bind ex_stage ex_stage_chk u_chk (
  .clk               (clk),
  .rst_n             (rst_n),
  .mult_multicycle_i (mult_multicycle_o),
  .ex_valid_i        (ex_valid_o),
  .lsu_ready_ex_i    (lsu_ready_ex_i),
  .wb_ready_i        (wb_ready_i),
  .lsu_spr_valid_i   (lsu_spr_sel_i.valid),
  .wb_we_i           (wb_port_o.we)
);

`default_nettype wire

/* tb/tb_ex_stage.sv */
/*
  Self-checking testbench of the execute stage at the default weight bank depth.
  LSU read data is driven in the write-back cycle as the stage expects.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage
  import ex_ops_pkg::*;
  import ex_port_pkg::*;
;

  localparam int CLK_HALF    = 5;
  localparam int DRIVE_DLY   = 1;     // Inputs change just after the edge
  localparam int N_RAND      = 4;     // Operand sets per case
  localparam int STALL_LIMIT = 8;
  localparam int TEST_CYCLES = 20 * N_RAND + 4 * N_WSPR_DEF + 24; // All tests plus reset
  localparam int TIMEOUT_NS  = TEST_CYCLES * 2 * CLK_HALF + 500;

  logic              clk;
  logic              rst_n;
  alu_req_t          alu_req;
  logic              alu_en;
  mult_req_t         mult_req;
  logic              mult_en;
  spr_sel_t          mult_spr_sel;
  logic              csr_access;
  logic [XLEN-1:0]   csr_rdata;
  logic              regfile_alu_we;
  logic [REG_AW-1:0] regfile_alu_waddr;
  logic              regfile_we;
  logic [REG_AW-1:0] regfile_waddr;
  logic              lsu_en;
  spr_sel_t          lsu_spr_sel;
  logic              branch_in_ex;
  logic              lsu_ready_ex;
  logic              lsu_err;
  logic [XLEN-1:0]   lsu_rdata;
  logic              wb_ready;
  fw_port_t          fw_port;
  wb_port_t          wb_port;
  logic              branch_decision;
  logic [XLEN-1:0]   jump_target;
  logic              mult_multicycle;
  logic              ex_ready;
  logic              ex_valid;

  integer seed;
  int     n_checks;
  int     n_errors;
  int     test_checks;    // Counts at test start
  int     test_errors;

  ex_stage #(.N_WSPR(N_WSPR_DEF)) UUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .mult_req_i          (mult_req),
    .mult_en_i           (mult_en),
    .mult_spr_sel_i      (mult_spr_sel),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .lsu_en_i            (lsu_en),
    .lsu_spr_sel_i       (lsu_spr_sel),
    .branch_in_ex_i      (branch_in_ex),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .lsu_err_i           (lsu_err),
    .lsu_rdata_i         (lsu_rdata),
    .wb_ready_i          (wb_ready),
    .fw_port_o           (fw_port),
    .wb_port_o           (wb_port),
    .branch_decision_o   (branch_decision),
    .jump_target_o       (jump_target),
    .mult_multicycle_o   (mult_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  always #CLK_HALF clk = ~clk;       // 10 ns period

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [XLEN-1:0] alu_model(input alu_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];                     // RV32 shift amount
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return $unsigned($signed(a) >>> sh);
      ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
      default:  return '0;
    endcase
  endfunction

  // Branch outcome with the SLT flavours
  function automatic logic cmp_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
    case (op)
      ALU_SLT, ALU_BLT: return $signed(a) < $signed(b);
      ALU_SLTU:         return a < b;
      ALU_BEQ:          return a == b;
      ALU_BNE:          return a != b;
      ALU_BGE:          return $signed(a) >= $signed(b);
      default:          return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] dot8_model(input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b,
                                                 input logic [XLEN-1:0] c);
    logic [XLEN-1:0]   acc;
    logic signed [7:0] x;
    logic signed [7:0] y;
    acc = c;
    for (int i = 0; i < 4; i++) begin
      x   = a[8*i +: 8];
      y   = b[8*i +: 8];
      acc = acc + 32'(int'(x) * int'(y));   // Signed byte lanes
    end
    return acc;
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  ////////////////////////////////////////
  // Drive and check helpers
  ////////////////////////////////////////
  task automatic set_idle();
    alu_req           = '0;
    alu_en            = 1'b0;
    mult_req          = '0;
    mult_en           = 1'b0;
    mult_spr_sel      = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    lsu_en            = 1'b0;
    lsu_spr_sel       = '0;
    lsu_err           = 1'b0;
    lsu_rdata         = '0;
    lsu_ready_ex      = 1'b1;
    wb_ready          = 1'b1;
    branch_in_ex      = 1'b0;
  endtask

  // Next cycle with all inputs back to idle
  task automatic start_cycle();
    @(posedge clk);
    #DRIVE_DLY;
    set_idle();
  endtask

  task automatic check_val(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  // Counts stalled cycles sampled mid-cycle
  task automatic wait_ready(output int stalls);
    stalls = 0;
    @(negedge clk);
    while (!ex_ready && stalls < STALL_LIMIT) begin
      stalls++;
      @(negedge clk);
    end
    assert (ex_ready) else begin
      $display("ERROR t=%0t ex_ready_o stayed low for %0d cycles", $time, STALL_LIMIT);
      n_errors++;
    end
  endtask

  task automatic begin_test();
    test_checks = n_checks;
    test_errors = n_errors;
  endtask

  task automatic end_test(input string name);
    $display("TEST %-10s %0d checks, %0d errors", name, n_checks - test_checks,
             n_errors - test_errors);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    int                stalls;
    logic [XLEN-1:0]   w [N_WSPR_DEF];   // Loaded weights
    logic [XLEN-1:0]   exp_word;
    logic [REG_AW-1:0] addr;
    seed = 32'h750c_7ef1;
    n_checks = 0;
    n_errors = 0;
    clk = 1'b0;
    rst_n = 1'b0;
    set_idle();
    repeat (3) @(posedge clk);
    #DRIVE_DLY rst_n = 1'b1;

    begin_test();
    @(negedge clk);
    check_val("wb_port_o.we", 32'(wb_port.we), 0);
    check_val("mult_multicycle_o", 32'(mult_multicycle), 0);
    check_val("fw_port_o.we", 32'(fw_port.we), 32'(regfile_alu_we));
    end_test("reset");

    // ALU and branch ops
    begin_test();
    for (int k = 0; k < 14; k++) begin
      for (int r = 0; r < N_RAND; r++) begin
        start_cycle();
        alu_req.op   = alu_op_e'(4'(k));
        alu_req.op_a = rand_word();
        alu_req.op_b = (r == 0) ? alu_req.op_a : rand_word();  // Equal pair
        alu_en = 1'b1;
        regfile_alu_we = 1'b1;
        regfile_alu_waddr = 6'($random(seed));
        wait_ready(stalls);
        check_val("ex_valid_o", 32'(ex_valid), 1);
        check_val("fw_port_o.we", 32'(fw_port.we), 1);
        check_val("fw_port_o.waddr", 32'(fw_port.waddr), 32'(regfile_alu_waddr));
        check_val("jump_target_o", jump_target, alu_req.op_b);
        if (k < int'(ALU_BEQ))
          check_val("fw_port_o.wdata", fw_port.wdata,
                    alu_model(alu_req.op, alu_req.op_a, alu_req.op_b));
        if (k >= int'(ALU_SLT))
          check_val("branch_decision_o", 32'(branch_decision),
                    32'(cmp_model(alu_req.op, alu_req.op_a, alu_req.op_b)));
      end
    end
    end_test("alu");

    // MUL then DOT8 with one stall cycle each
    begin_test();
    for (int r = 0; r < 2 * N_RAND; r++) begin
      start_cycle();
      mult_req.op   = (r < N_RAND) ? MULT_MUL : MULT_DOT8;
      mult_req.op_a = rand_word();
      mult_req.op_b = rand_word();
      mult_req.op_c = rand_word();
      mult_en = 1'b1;
      regfile_alu_we = 1'b1;
      exp_word = (r < N_RAND) ? mult_req.op_a * mult_req.op_b
                              : dot8_model(mult_req.op_a, mult_req.op_b, mult_req.op_c);
      if (r == 2 * N_RAND - 1) begin
        csr_access = 1'b1;            // CSR beats the multiplier
        csr_rdata  = rand_word();
        exp_word   = csr_rdata;
      end
      wait_ready(stalls);
      check_val("ex_ready_o low cycles", stalls, 1);
      check_val("fw_port_o.wdata", fw_port.wdata, exp_word);
    end
    end_test("mult");

    // Loads into weight registers then DOT8 on each
    begin_test();
    for (int k = 0; k < N_WSPR_DEF; k++) begin
      w[k] = rand_word();
      start_cycle();
      lsu_en = 1'b1;
      regfile_we = 1'b1;
      regfile_waddr = 6'($random(seed));
      lsu_spr_sel = '{valid: 1'b1, idx: 2'(k)};
      wait_ready(stalls);
      check_val("ex_valid_o", 32'(ex_valid), 1);
      start_cycle();
      lsu_rdata = w[k];               // Data in the WB cycle
      @(negedge clk);
      check_val("wb_port_o.we", 32'(wb_port.we), 0);
    end
    for (int k = 0; k < N_WSPR_DEF; k++) begin
      start_cycle();
      mult_req.op   = MULT_DOT8;
      mult_req.op_a = rand_word();    // Replaced by the weight
      mult_req.op_b = rand_word();
      mult_req.op_c = rand_word();
      mult_spr_sel  = '{valid: 1'b1, idx: 2'(k)};
      mult_en = 1'b1;
      wait_ready(stalls);
      check_val("fw_port_o.wdata", fw_port.wdata,
                dot8_model(w[k], mult_req.op_b, mult_req.op_c));
    end
    end_test("weights");

    // Back-pressure from WB then a faulted load
    begin_test();
    start_cycle();
    mult_req.op   = MULT_MUL;
    mult_req.op_a = rand_word();
    mult_req.op_b = rand_word();
    mult_en  = 1'b1;
    wb_ready = 1'b0;
    exp_word = mult_req.op_a * mult_req.op_b;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_val("ex_ready_o", 32'(ex_ready), 0);
      check_val("ex_valid_o", 32'(ex_valid), 0);
      check_val("mult_multicycle_o", 32'(mult_multicycle), 32'(c == 0)); // Start cycle only
      if (c > 0)
        check_val("fw_port_o.wdata", fw_port.wdata, exp_word);  // Held result
    end
    @(posedge clk);
    #DRIVE_DLY wb_ready = 1'b1;
    wait_ready(stalls);
    check_val("ex_ready_o low cycles", stalls, 0);
    check_val("ex_valid_o", 32'(ex_valid), 1);
    check_val("fw_port_o.wdata", fw_port.wdata, exp_word);
    start_cycle();
    wb_ready = 1'b0;
    branch_in_ex = 1'b1;              // Branch leaves EX anyway
    alu_en = 1'b1;
    @(negedge clk);
    check_val("ex_ready_o", 32'(ex_ready), 1);
    check_val("ex_valid_o", 32'(ex_valid), 0);
    start_cycle();
    lsu_en = 1'b1;
    regfile_we = 1'b1;
    lsu_err = 1'b1;
    regfile_waddr = 6'($random(seed));
    wait_ready(stalls);
    check_val("ex_valid_o", 32'(ex_valid), 1);
    start_cycle();
    lsu_rdata = rand_word();
    @(negedge clk);
    check_val("wb_port_o.we", 32'(wb_port.we), 0);
    end_test("stall");

    // Plain loads to GPRs
    begin_test();
    for (int r = 0; r < N_RAND; r++) begin
      addr = 6'($random(seed));
      start_cycle();
      lsu_en = 1'b1;
      regfile_we = 1'b1;
      regfile_waddr = addr;
      wait_ready(stalls);
      check_val("ex_valid_o", 32'(ex_valid), 1);
      start_cycle();
      lsu_rdata = rand_word();
      @(negedge clk);
      check_val("wb_port_o.we", 32'(wb_port.we), 1);
      check_val("wb_port_o.waddr", 32'(wb_port.waddr), 32'(addr));
      check_val("wb_port_o.wdata", wb_port.wdata, lsu_rdata);
    end
    start_cycle();
    @(negedge clk);
    check_val("wb_port_o.we", 32'(wb_port.we), 0);
    end_test("load");

    $display("SUMMARY: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #TIMEOUT_NS;
    $display("Watchdog expired after %0d ns, a test did not finish", TIMEOUT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/ex_ops_pkg.sv
hdl/ex_port_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_weight_spr.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
tb/ex_stage_chk.sv
tb/tb_ex_stage.sv
